//--- axi_bridge_params.svh
`ifndef AXI_BRIDGE_PARAMS_SVH
`define AXI_BRIDGE_PARAMS_SVH

// Both sides of the bridge share one address width and one data width
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// Transaction id width on the AXI side
`define AXI_ID_W 4

// Width of the AXI burst length field, so up to 256 beats per burst
`define AXI_LEN_W 8

// Bursts never cross a 4 KB page, so only these low bits ever step
`define AXI_PAGE_BITS 12

// Outstanding bursts per channel between address and response stage
`define XACT_FIFO_DEPTH 4

`endif

//--- axi_bridge_pkg.sv
`default_nettype none
`include "axi_bridge_params.svh"

package axi_bridge_pkg;

    // AXI burst type encodings, code 2'b11 is reserved
    typedef enum logic [1:0] {FIXED = 2'b00, INCR = 2'b01, WRAP = 2'b10} burst_t;

    // Response codes, bit 1 set marks an error
    typedef enum logic [1:0] {OKAY = 2'b00, EXOKAY = 2'b01, SLVERR = 2'b10, DECERR = 2'b11} resp_t;

    // Splitter is either forwarding a fresh beat or replaying a burst
    typedef enum logic {IDLE = 1'b0, BURST = 1'b1} split_state_t;

    // One full AXI address beat
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
        logic [2:0]             size;
        burst_t                 burst;
        logic [2:0]             prot;
    } axi_addr_t;

    // A Lite address beat only has address and protection
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [2:0]             prot;
    } lite_addr_t;

    // Burst bookkeeping passed from an address stage to its response stage
    typedef struct packed {
        logic [`AXI_ID_W-1:0]  id;
        logic [`AXI_LEN_W-1:0] len;
    } xact_t;

    // Address of the beat following addr within a burst
    function automatic logic [`AXI_ADDR_W-1:0] next_addr(
        input logic [`AXI_ADDR_W-1:0] addr,
        input logic [2:0]             size,
        input logic [3:0]             wrap_len,
        input burst_t                 burst
    );
        logic [`AXI_PAGE_BITS-1:0] low;
        logic [`AXI_PAGE_BITS-1:0] step;
        logic [`AXI_PAGE_BITS-1:0] wrap_mask;
        logic [`AXI_PAGE_BITS-1:0] stepped;
        low  = addr[`AXI_PAGE_BITS-1:0];
        step = `AXI_PAGE_BITS'(1) << size;
        // Legal wrap lengths are 1, 3, 7 or 15, which already form a bit mask
        wrap_mask = `AXI_PAGE_BITS'(wrap_len) << size;
        case (burst)
            // Align down to the beat size first, then step one beat
            INCR: stepped = (low & ~(step - 1'b1)) + step;
            // Carry out of the wrap block is masked off so the address folds back
            WRAP: stepped = ((low + step) & wrap_mask) | (low & ~wrap_mask);
            default: stepped = low;
        endcase
        // Bits above the page never change
        return {addr[`AXI_ADDR_W-1:`AXI_PAGE_BITS], stepped};
    endfunction

endpackage

`default_nettype wire

//--- axi_burst_splitter.sv
`default_nettype none
`include "axi_bridge_params.svh"

module axi_burst_splitter (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       axi_valid,
    output logic                      axi_ready,
    input  axi_bridge_pkg::axi_addr_t axi_beat,
    output logic                      lite_valid,
    input  wire                       lite_ready,
    output axi_bridge_pkg::lite_addr_t lite_beat,
    output logic                      fifo_push,
    input  wire                       fifo_full,
    output axi_bridge_pkg::xact_t     fifo_data
);
    import axi_bridge_pkg::*;

    split_state_t           state;
    // Fields latched from the AXI beat for the rest of the burst
    logic [2:0]             size_q;
    burst_t                 burst_q;
    logic [3:0]             wrap_len_q;
    logic [2:0]             prot_q;
    logic [`AXI_ADDR_W-1:0] addr_q;
    // Lite beats still to issue after the current one
    logic [`AXI_LEN_W-1:0]  remain_q;
    // Switched fields come from the AXI beat in IDLE and from the latches in BURST
    logic [2:0]             size_sw;
    burst_t                 burst_sw;
    logic [3:0]             wrap_len_sw;
    logic [`AXI_ADDR_W-1:0] addr_next;
    logic                   idle_open;
    logic                   axi_fire;

    assign size_sw     = (state == BURST) ? size_q : axi_beat.size;
    assign burst_sw    = (state == BURST) ? burst_q : axi_beat.burst;
    assign wrap_len_sw = (state == BURST) ? wrap_len_q : axi_beat.len[3:0];

    // Step from the address currently on the Lite side
    assign addr_next = next_addr(lite_beat.addr, size_sw, wrap_len_sw, burst_sw);

    // A new burst may only start when its bookkeeping has room in the FIFO
    assign idle_open  = (state == IDLE) && !fifo_full;
    assign axi_ready  = idle_open && lite_ready;
    assign lite_valid = (state == BURST) || (axi_valid && idle_open);
    assign lite_beat  = (state == BURST) ? lite_addr_t'{addr: addr_q, prot: prot_q}
                                         : lite_addr_t'{addr: axi_beat.addr, prot: axi_beat.prot};

    // The first beat of every burst records id and length for the response side
    assign axi_fire  = axi_valid && axi_ready;
    assign fifo_push = axi_fire;
    assign fifo_data = xact_t'{id: axi_beat.id, len: axi_beat.len};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= IDLE;
            remain_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // Single beats complete in IDLE, longer bursts replay the rest
                    if (axi_fire && axi_beat.len != '0) begin
                        state    <= BURST;
                        remain_q <= axi_beat.len;
                    end
                end
                BURST: begin
                    if (lite_ready) begin
                        remain_q <= remain_q - 1'b1;
                        if (remain_q == `AXI_LEN_W'(1)) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (axi_fire) begin
            size_q     <= axi_beat.size;
            burst_q    <= axi_beat.burst;
            wrap_len_q <= axi_beat.len[3:0];
            prot_q     <= axi_beat.prot;
            addr_q     <= addr_next;
        end else if (state == BURST && lite_ready) begin
            addr_q <= addr_next;
        end
    end

    // No new AXI beat may be taken while a burst is being replayed
    a_no_ready_in_burst: assert property (
        @(posedge clk) disable iff (!rstn) (state == BURST) |-> !axi_ready
    );

    // A stalled Lite beat stays on the bus unchanged
    // In IDLE that depends on the AXI master holding its address beat
    a_lite_beat_held: assert property (
        @(posedge clk) disable iff (!rstn)
        lite_valid && !lite_ready |=> lite_valid && $stable(lite_beat)
    );

endmodule

`default_nettype wire

//--- axi_to_lite.f
+incdir+.
axi_bridge_pkg.sv
axi_burst_splitter.sv
xact_fifo.sv
read_resp_tracker.sv
write_resp_merger.sv
axi_to_lite.sv
tb_lite_mem.sv
tb_axi_to_lite.sv

//--- axi_to_lite.sv
`default_nettype none
`include "axi_bridge_params.svh"

module axi_to_lite (
    input  wire                        clk,
    input  wire                        rstn,
    // AXI slave side
    input  wire                        ar_valid,
    output logic                       ar_ready,
    input  axi_bridge_pkg::axi_addr_t  ar,
    output logic                       r_valid,
    input  wire                        r_ready,
    output logic [`AXI_ID_W-1:0]       r_id,
    output logic [`AXI_DATA_W-1:0]     r_data,
    output axi_bridge_pkg::resp_t      r_resp,
    output logic                       r_last,
    input  wire                        aw_valid,
    output logic                       aw_ready,
    input  axi_bridge_pkg::axi_addr_t  aw,
    input  wire                        w_valid,
    output logic                       w_ready,
    input  wire [`AXI_DATA_W-1:0]      w_data,
    input  wire [`AXI_DATA_W/8-1:0]    w_strb,
    output logic                       b_valid,
    input  wire                        b_ready,
    output logic [`AXI_ID_W-1:0]       b_id,
    output axi_bridge_pkg::resp_t      b_resp,
    // Lite master side
    output logic                       lite_ar_valid,
    input  wire                        lite_ar_ready,
    output axi_bridge_pkg::lite_addr_t lite_ar,
    input  wire                        lite_r_valid,
    output logic                       lite_r_ready,
    input  wire [`AXI_DATA_W-1:0]      lite_r_data,
    input  axi_bridge_pkg::resp_t      lite_r_resp,
    output logic                       lite_aw_valid,
    input  wire                        lite_aw_ready,
    output axi_bridge_pkg::lite_addr_t lite_aw,
    output logic                       lite_w_valid,
    input  wire                        lite_w_ready,
    output logic [`AXI_DATA_W-1:0]     lite_w_data,
    output logic [`AXI_DATA_W/8-1:0]   lite_w_strb,
    input  wire                        lite_b_valid,
    output logic                       lite_b_ready,
    input  axi_bridge_pkg::resp_t      lite_b_resp
);
    import axi_bridge_pkg::*;

    // Read and write bookkeeping travel through separate FIFOs
    xact_t ar_xact, r_xact, aw_xact, b_xact;
    logic  ar_push, rfifo_full, r_pop, rfifo_empty;
    logic  aw_push, wfifo_full, b_pop, wfifo_empty;

    axi_burst_splitter u_ar_split (
        .clk(clk), .rstn(rstn),
        .axi_valid(ar_valid), .axi_ready(ar_ready), .axi_beat(ar),
        .lite_valid(lite_ar_valid), .lite_ready(lite_ar_ready), .lite_beat(lite_ar),
        .fifo_push(ar_push), .fifo_full(rfifo_full), .fifo_data(ar_xact)
    );

    axi_burst_splitter u_aw_split (
        .clk(clk), .rstn(rstn),
        .axi_valid(aw_valid), .axi_ready(aw_ready), .axi_beat(aw),
        .lite_valid(lite_aw_valid), .lite_ready(lite_aw_ready), .lite_beat(lite_aw),
        .fifo_push(aw_push), .fifo_full(wfifo_full), .fifo_data(aw_xact)
    );

    xact_fifo u_rfifo (
        .clk(clk), .rstn(rstn),
        .push(ar_push), .push_data(ar_xact), .full(rfifo_full),
        .pop(r_pop), .pop_data(r_xact), .empty(rfifo_empty)
    );

    xact_fifo u_wfifo (
        .clk(clk), .rstn(rstn),
        .push(aw_push), .push_data(aw_xact), .full(wfifo_full),
        .pop(b_pop), .pop_data(b_xact), .empty(wfifo_empty)
    );

    read_resp_tracker u_read_resp (
        .clk(clk), .rstn(rstn),
        .lite_r_valid(lite_r_valid), .lite_r_ready(lite_r_ready),
        .lite_r_data(lite_r_data), .lite_r_resp(lite_r_resp),
        .r_valid(r_valid), .r_ready(r_ready), .r_id(r_id),
        .r_data(r_data), .r_resp(r_resp), .r_last(r_last),
        .xact(r_xact), .xact_empty(rfifo_empty), .xact_pop(r_pop)
    );

    write_resp_merger u_write_resp (
        .clk(clk), .rstn(rstn),
        .lite_b_valid(lite_b_valid), .lite_b_ready(lite_b_ready), .lite_b_resp(lite_b_resp),
        .b_valid(b_valid), .b_ready(b_ready), .b_id(b_id), .b_resp(b_resp),
        .xact(b_xact), .xact_empty(wfifo_empty), .xact_pop(b_pop)
    );

    // Write data goes straight across, bursts are never interrupted so w_last is not needed
    assign lite_w_valid = w_valid;
    assign w_ready      = lite_w_ready;
    assign lite_w_data  = w_data;
    assign lite_w_strb  = w_strb;

endmodule

`default_nettype wire

//--- read_resp_tracker.sv
`default_nettype none
`include "axi_bridge_params.svh"

module read_resp_tracker (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     lite_r_valid,
    output logic                    lite_r_ready,
    input  wire [`AXI_DATA_W-1:0]   lite_r_data,
    input  axi_bridge_pkg::resp_t   lite_r_resp,
    output logic                    r_valid,
    input  wire                     r_ready,
    output logic [`AXI_ID_W-1:0]    r_id,
    output logic [`AXI_DATA_W-1:0]  r_data,
    output axi_bridge_pkg::resp_t   r_resp,
    output logic                    r_last,
    input  axi_bridge_pkg::xact_t   xact,
    input  wire                     xact_empty,
    output logic                    xact_pop
);

    logic                  in_burst;
    logic [`AXI_ID_W-1:0]  id_q;
    // Beats of the current burst still expected after the last one seen
    logic [`AXI_LEN_W-1:0] remain_q;
    logic                  beat_fire;

    // Data path is a straight pass, only id and last are rebuilt
    assign r_valid      = lite_r_valid;
    assign lite_r_ready = r_ready;
    assign r_data       = lite_r_data;
    assign r_resp       = lite_r_resp;
    assign beat_fire    = lite_r_valid && lite_r_ready;

    // The FIFO head describes the burst until its first beat has gone through
    assign r_id     = in_burst ? id_q : xact.id;
    assign r_last   = in_burst ? (remain_q == `AXI_LEN_W'(1)) : (xact.len == '0);
    assign xact_pop = !in_burst && beat_fire;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_burst <= 1'b0;
            remain_q <= '0;
        end else if (beat_fire) begin
            if (!in_burst) begin
                in_burst <= xact.len != '0;
                remain_q <= xact.len;
            end else begin
                remain_q <= remain_q - 1'b1;
                if (remain_q == `AXI_LEN_W'(1)) begin
                    in_burst <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xact_pop) begin
            id_q <= xact.id;
        end
    end

    // Read data with nothing outstanding means the slave answered an unissued read
    a_r_has_request: assert property (
        @(posedge clk) disable iff (!rstn) lite_r_valid && !in_burst |-> !xact_empty
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f axi_to_lite.f --top-module tb_axi_to_lite -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_tb; then
    echo "Simulation returned a failing status"
    exit 1
fi

exit 0

//--- tb_axi_to_lite.sv
`default_nettype none
`include "axi_bridge_params.svh"

module tb_axi_to_lite;
    timeunit 1ns;
    timeprecision 1ns;
    import axi_bridge_pkg::*;

    logic clk, rstn, stall_en, mem_stall;
    logic ar_valid, ar_ready, r_valid, r_ready, r_last;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    axi_addr_t ar, aw;
    logic [`AXI_ID_W-1:0] r_id, b_id;
    logic [`AXI_DATA_W-1:0] r_data, w_data;
    logic [`AXI_DATA_W/8-1:0] w_strb;
    resp_t r_resp, b_resp;
    logic lite_ar_valid, lite_ar_ready, lite_r_valid, lite_r_ready;
    logic lite_aw_valid, lite_aw_ready, lite_w_valid, lite_w_ready;
    logic lite_b_valid, lite_b_ready;
    lite_addr_t lite_ar, lite_aw;
    logic [`AXI_DATA_W-1:0] lite_r_data, lite_w_data;
    logic [`AXI_DATA_W/8-1:0] lite_w_strb;
    resp_t lite_r_resp, lite_b_resp;

    logic [31:0] lfsr_state;
    logic [31:0] wd [32];
    logic [31:0] ref_mem [256];
    string test_name;
    // Expected values, pushed when a burst is issued and popped by the monitors
    lite_addr_t exp_ar[$], exp_aw[$];
    logic [31:0] exp_r_data[$], exp_r_id[$];
    logic [31:0] exp_r_last[$], exp_b_id[$], exp_b_resp[$];
    // Lite address beat currently being compared by the monitor
    lite_addr_t exp_beat;

    axi_to_lite u_axi_to_lite (.*);

    tb_lite_mem u_mem (.clk(clk), .rstn(rstn), .stall(mem_stall), .lite_ar_valid(lite_ar_valid),
        .lite_ar_ready(lite_ar_ready), .lite_ar(lite_ar), .lite_r_valid(lite_r_valid),
        .lite_r_ready(lite_r_ready), .lite_r_data(lite_r_data), .lite_r_resp(lite_r_resp),
        .lite_aw_valid(lite_aw_valid), .lite_aw_ready(lite_aw_ready), .lite_aw(lite_aw),
        .lite_w_valid(lite_w_valid), .lite_w_ready(lite_w_ready), .lite_w_data(lite_w_data),
        .lite_w_strb(lite_w_strb), .lite_b_valid(lite_b_valid), .lite_b_ready(lite_b_ready),
        .lite_b_resp(lite_b_resp));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h80200003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] v;
        for (int i = 0; i < 32; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    // Address of beat i, from the AXI burst rules
    function automatic logic [31:0] beat_addr(input logic [31:0] start, input int beats,
                                              input burst_t burst, input int i);
        logic [31:0] block;
        logic [31:0] base;
        block = 32'(4 * beats);
        base  = start & ~(block - 1);
        case (burst)
            FIXED: return start;
            WRAP: return base + ((start - base + 32'(4 * i)) % block);
            default: return (i == 0) ? start : (start & ~32'h3) + 32'(4 * i);
        endcase
    endfunction

    task automatic end_in_failure();
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s in test %s", msg, test_name);
        end_in_failure();
    endtask

    task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, exp, act);
            end_in_failure();
        end
    endtask

    // Random stalls on the Lite slave and the master's ready lines
    initial begin
        mem_stall = 1'b0;
        r_ready   = 1'b1;
        b_ready   = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (stall_en) begin
                mem_stall = lfsr_bit();
                r_ready   = lfsr_bit();
                b_ready   = lfsr_bit();
            end
        end
    end

    // Monitors sample at the falling edge, where every handshake signal is settled
    always @(negedge clk) begin
        if (rstn) begin
            if (lite_ar_valid && lite_ar_ready) begin
                if (exp_ar.size() == 0) abort_run("Unexpected Lite read address");
                else begin
                    exp_beat = exp_ar.pop_front();
                    check_equal("lite_ar addr", exp_beat.addr, lite_ar.addr);
                    check_equal("lite_ar prot", 32'(exp_beat.prot), 32'(lite_ar.prot));
                end
            end
            if (lite_aw_valid && lite_aw_ready) begin
                if (exp_aw.size() == 0) abort_run("Unexpected Lite write address");
                else begin
                    exp_beat = exp_aw.pop_front();
                    check_equal("lite_aw addr", exp_beat.addr, lite_aw.addr);
                    check_equal("lite_aw prot", 32'(exp_beat.prot), 32'(lite_aw.prot));
                end
            end
            if (r_valid && r_ready) begin
                if (exp_r_data.size() == 0) abort_run("AXI read beat with no read outstanding");
                else begin
                    check_equal("r_id", exp_r_id.pop_front(), 32'(r_id));
                    check_equal("r_data", exp_r_data.pop_front(), r_data);
                    check_equal("r_last", exp_r_last.pop_front(), 32'(r_last));
                    check_equal("r_resp", 32'(OKAY), 32'(r_resp));
                end
            end
            if (b_valid && b_ready) begin
                if (exp_b_id.size() == 0) abort_run("AXI write response with no burst pending");
                else begin
                    check_equal("b_id", exp_b_id.pop_front(), 32'(b_id));
                    check_equal("b_resp", exp_b_resp.pop_front(), 32'(b_resp));
                end
            end
        end
    end

    // A stalled response beat must not change until it is taken
    a_r_held: assert property (@(posedge clk) disable iff (!rstn)
        r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_id) && $stable(r_last))
        else abort_run("AXI read beat changed while stalled");

    a_b_held: assert property (@(posedge clk) disable iff (!rstn)
        b_valid && !b_ready |=> b_valid && $stable(b_id) && $stable(b_resp))
        else abort_run("AXI write response changed while stalled");

    task automatic write_burst(input int id, input logic [31:0] addr, input int len,
                               input burst_t burst, input int k);
        logic [31:0] a;
        logic any_err;
        logic aw_done;
        logic hs_aw;
        logic hs_w;
        int wi;
        int cycles;
        any_err = 1'b0;
        for (int i = 0; i <= len; i++) begin
            a = beat_addr(addr, len + 1, burst, i);
            exp_aw.push_back(lite_addr_t'{addr: a, prot: 3'(id)});
            if (a >= 32'h80 && a <= 32'h8f) any_err = 1'b1;
            else ref_mem[a[9:2]] = wd[k + i];
        end
        exp_b_id.push_back(32'(id));
        exp_b_resp.push_back(any_err ? 32'(SLVERR) : 32'(OKAY));
        @(posedge clk);
        #1;
        aw = '{id: id, addr: addr, len: len, size: 3'd2, burst: burst, prot: 3'(id)};
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        w_data   = wd[k];
        aw_done  = 1'b0;
        wi       = 0;
        cycles   = 0;
        while (!aw_done || wi <= len) begin
            @(negedge clk);
            hs_aw = aw_valid && aw_ready;
            hs_w  = w_valid && w_ready;
            @(posedge clk);
            #1;
            if (hs_aw) begin
                aw_done  = 1'b1;
                aw_valid = 1'b0;
            end
            if (hs_w) begin
                wi++;
                if (wi > len) w_valid = 1'b0;
                else w_data = wd[k + wi];
            end
            cycles++;
            if (cycles > 1000) abort_run("Timeout while sending a write burst");
        end
    endtask

    task automatic read_burst(input int id, input logic [31:0] addr, input int len,
                              input burst_t burst);
        logic [31:0] a;
        logic hs;
        int cycles;
        for (int i = 0; i <= len; i++) begin
            a = beat_addr(addr, len + 1, burst, i);
            exp_ar.push_back(lite_addr_t'{addr: a, prot: 3'(id)});
            exp_r_data.push_back(ref_mem[a[9:2]]);
            exp_r_id.push_back(32'(id));
            exp_r_last.push_back(32'(i == len));
        end
        @(posedge clk);
        #1;
        ar = '{id: id, addr: addr, len: len, size: 3'd2, burst: burst, prot: 3'(id)};
        ar_valid = 1'b1;
        hs = 1'b0;
        cycles = 0;
        while (!hs) begin
            @(negedge clk);
            hs = ar_valid && ar_ready;
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 1000) abort_run("Timeout waiting for ar_ready");
        end
        ar_valid = 1'b0;
    endtask

    // Waits until every expected beat has been seen
    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_ar.size() + exp_aw.size() + exp_r_data.size()
               + exp_b_id.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 3000) abort_run("Timeout waiting for outstanding responses");
        end
    endtask

    initial begin
        rstn = 1'b0;
        stall_en = 1'b0;
        ar_valid = 1'b0;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        ar = '0;
        aw = '0;
        w_data = '0;
        w_strb = 4'hf;
        lfsr_state = 32'h6be3af57;
        for (int i = 0; i < 32; i++) begin
            wd[i] = rand_word();
        end
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_name = "single_beat";
        write_burst(3, 32'h10, 0, INCR, 0);
        wait_drained();
        read_burst(5, 32'h10, 0, INCR);
        wait_drained();

        test_name = "incr_burst";
        write_burst(1, 32'h22, 3, INCR, 1);
        wait_drained();
        read_burst(2, 32'h20, 3, INCR);
        wait_drained();

        test_name = "wrap_fixed";
        write_burst(4, 32'h48, 3, WRAP, 5);
        wait_drained();
        read_burst(6, 32'h44, 3, WRAP);
        write_burst(7, 32'h60, 2, FIXED, 9);
        wait_drained();
        read_burst(8, 32'h60, 2, FIXED);
        wait_drained();

        test_name = "error_merge";
        write_burst(9, 32'h78, 3, INCR, 12);
        wait_drained();
        write_burst(10, 32'h90, 3, INCR, 16);
        wait_drained();

        test_name = "backpressure";
        stall_en = 1'b1;
        write_burst(11, 32'ha0, 3, INCR, 20);
        wait_drained();
        // Four read bursts issued back to back, so several are in flight at once
        read_burst(12, 32'h20, 3, INCR);
        read_burst(13, 32'h44, 3, WRAP);
        read_burst(14, 32'h90, 3, INCR);
        read_burst(15, 32'ha0, 3, INCR);
        wait_drained();
        stall_en = 1'b0;

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_lite_mem.sv
`default_nettype none
`include "axi_bridge_params.svh"

module tb_lite_mem (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        stall,
    input  wire                        lite_ar_valid,
    output logic                       lite_ar_ready,
    input  axi_bridge_pkg::lite_addr_t lite_ar,
    output logic                       lite_r_valid,
    input  wire                        lite_r_ready,
    output logic [`AXI_DATA_W-1:0]     lite_r_data,
    output axi_bridge_pkg::resp_t      lite_r_resp,
    input  wire                        lite_aw_valid,
    output logic                       lite_aw_ready,
    input  axi_bridge_pkg::lite_addr_t lite_aw,
    input  wire                        lite_w_valid,
    output logic                       lite_w_ready,
    input  wire [`AXI_DATA_W-1:0]      lite_w_data,
    input  wire [`AXI_DATA_W/8-1:0]    lite_w_strb,
    output logic                       lite_b_valid,
    input  wire                        lite_b_ready,
    output axi_bridge_pkg::resp_t      lite_b_resp
);
    timeunit 1ns;
    timeprecision 1ns;
    import axi_bridge_pkg::*;

    logic [`AXI_DATA_W-1:0] mem [256];
    logic                   wr_go;

    // Byte addresses 0x80 to 0x8F answer with a slave error
    function automatic logic in_err_window(input logic [`AXI_ADDR_W-1:0] a);
        return a >= 32'h80 && a <= 32'h8f;
    endfunction

    // One read and one write may be pending, and stall blocks new requests
    assign lite_ar_ready = !lite_r_valid && !stall;
    assign wr_go         = lite_aw_valid && lite_w_valid && !lite_b_valid && !stall;
    assign lite_aw_ready = wr_go;
    assign lite_w_ready  = wr_go;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lite_r_valid <= 1'b0;
            lite_b_valid <= 1'b0;
        end else begin
            if (lite_ar_valid && lite_ar_ready) begin
                lite_r_valid <= 1'b1;
                lite_r_data  <= mem[lite_ar.addr[9:2]];
                lite_r_resp  <= in_err_window(lite_ar.addr) ? SLVERR : OKAY;
            end else if (lite_r_ready) begin
                lite_r_valid <= 1'b0;
            end
            if (wr_go) begin
                lite_b_valid <= 1'b1;
                lite_b_resp  <= in_err_window(lite_aw.addr) ? SLVERR : OKAY;
                // Writes into the error window leave the memory unchanged
                if (!in_err_window(lite_aw.addr)) begin
                    for (int i = 0; i < `AXI_DATA_W / 8; i++) begin
                        if (lite_w_strb[i]) begin
                            mem[lite_aw.addr[9:2]][i*8 +: 8] <= lite_w_data[i*8 +: 8];
                        end
                    end
                end
            end else if (lite_b_ready) begin
                lite_b_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- write_resp_merger.sv
`default_nettype none
`include "axi_bridge_params.svh"

module write_resp_merger (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   lite_b_valid,
    output logic                  lite_b_ready,
    input  axi_bridge_pkg::resp_t lite_b_resp,
    output logic                  b_valid,
    input  wire                   b_ready,
    output logic [`AXI_ID_W-1:0]  b_id,
    output axi_bridge_pkg::resp_t b_resp,
    input  axi_bridge_pkg::xact_t xact,
    input  wire                   xact_empty,
    output logic                  xact_pop
);
    import axi_bridge_pkg::*;

    logic                  in_burst;
    logic [`AXI_ID_W-1:0]  id_q;
    logic [`AXI_LEN_W-1:0] remain_q;
    // Response accumulated over the Lite beats seen so far
    resp_t                 acc_q;
    resp_t                 resp_merged;
    logic                  last_beat;
    logic                  beat_fire;

    assign last_beat = in_burst ? (remain_q == `AXI_LEN_W'(1)) : (xact.len == '0);

    // Once an error is recorded it sticks, otherwise the newest code is taken
    assign resp_merged = (in_burst && acc_q[1]) ? acc_q : lite_b_resp;

    // Only the final Lite response reaches the master
    assign b_valid      = last_beat && lite_b_valid;
    assign lite_b_ready = last_beat ? b_ready : 1'b1;
    assign b_id         = in_burst ? id_q : xact.id;
    assign b_resp       = resp_merged;

    assign beat_fire = lite_b_valid && lite_b_ready;
    assign xact_pop  = !in_burst && beat_fire;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_burst <= 1'b0;
            remain_q <= '0;
        end else if (beat_fire) begin
            if (!in_burst) begin
                in_burst <= xact.len != '0;
                remain_q <= xact.len;
            end else begin
                remain_q <= remain_q - 1'b1;
                if (remain_q == `AXI_LEN_W'(1)) begin
                    in_burst <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xact_pop) begin
            id_q <= xact.id;
        end
        if (beat_fire) begin
            acc_q <= resp_merged;
        end
    end

    // A write response must belong to a burst whose address was sent
    a_b_has_request: assert property (
        @(posedge clk) disable iff (!rstn) lite_b_valid && !in_burst |-> !xact_empty
    );

endmodule

`default_nettype wire

//--- xact_fifo.sv
`default_nettype none
`include "axi_bridge_params.svh"

module xact_fifo (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   push,
    input  axi_bridge_pkg::xact_t push_data,
    output logic                  full,
    input  wire                   pop,
    output axi_bridge_pkg::xact_t pop_data,
    output logic                  empty
);
    import axi_bridge_pkg::*;

    localparam int DEPTH = `XACT_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    xact_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // One extra bit so a full buffer can be told apart from an empty one
    logic [PTR_W:0]   count;

    assign full     = count == (PTR_W + 1)'(DEPTH);
    assign empty    = count == '0;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap explicitly so any depth works
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // The splitter must hold off when no entry is free
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn) push |-> !full);
    // Response stages only pop for a burst that was issued
    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty);

endmodule

`default_nettype wire
